/* sources.f */
hdl/renamePkg.sv
hdl/regFile.sv
hdl/reorderBuffer.sv
hdl/renameCore.sv
sim/renameCoreTb.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  # shared package first, then the leaf modules and the top level
  - hdl/renamePkg.sv
  - hdl/regFile.sv
  - hdl/reorderBuffer.sv
  - hdl/renameCore.sv
  - target: simulation
    files:
      - sim/renameCoreTb.sv

/* sim/renameCoreTb.sv */
`timescale 1ns/100ps

module renameCoreTb;

    import renamePkg::*;

    localparam int TAG_W       = 4;
    localparam int NUM_ENTRIES = (1 << TAG_W) - 1;
    // the tests take a few hundred cycles, so this leaves ample margin
    localparam int CYCLE_LIMIT = 2000;

    typedef logic [TAG_W-1:0] robTag_t;

    logic      clk;
    logic      rst;
    logic      dispatchValid;
    regIndex_t dispatchDest;
    robTag_t   dispatchTag;
    logic      robFull;
    logic      completeValid;
    robTag_t   completeTag;
    word_t     completeData;
    regIndex_t readIndexA;
    regIndex_t readIndexB;
    operand_t  operandA;
    operand_t  operandB;
    robTag_t   operandTagA;
    robTag_t   operandTagB;
    logic      commitValid;
    commit_t   commit;

    // ======================================================================
    // reference model state
    // ======================================================================

    word_t     modelValue [NUM_ARCH_REGS];
    robTag_t   modelTag   [NUM_ARCH_REGS];
    robTag_t   modelTail;
    // live entries in program order, oldest first
    robTag_t   liveTag  [$];
    regIndex_t liveDest [$];
    logic      liveDone [$];
    word_t     liveData [$];

    // every commit seen on the outputs, in the order it happened
    commit_t   seenCommits [$];
    // read ports that the next cycle applies
    regIndex_t nextReadA;
    regIndex_t nextReadB;
    // tag reported for the dispatch driven in the latest cycle
    robTag_t   lastTag;
    logic [31:0] randState;
    int        cycleCount = 0;

    renameCore #(
        .ROB_EN_WIDTH(TAG_W)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .dispatchValid(dispatchValid),
        .dispatchDest (dispatchDest),
        .dispatchTag  (dispatchTag),
        .robFull      (robFull),
        .completeValid(completeValid),
        .completeTag  (completeTag),
        .completeData (completeData),
        .readIndexA   (readIndexA),
        .readIndexB   (readIndexB),
        .operandA     (operandA),
        .operandB     (operandB),
        .operandTagA  (operandTagA),
        .operandTagB  (operandTagB),
        .commitValid  (commitValid),
        .commit       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            failRun("timeout: the tests did not finish within 2000 clock cycles");
        end
    end

    // ======================================================================
    // failure reporting and compare tasks
    // ======================================================================

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compareBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("ERROR at %0t: %s expected %0b, got %0b",
                              $time, name, expected, actual));
        end
    endtask

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            failRun($sformatf("ERROR at %0t: %s expected %h, got %h",
                              $time, name, expected, actual));
        end
    endtask

    task automatic compareTag(input string name, input robTag_t expected,
                              input robTag_t actual);
        if (actual !== expected) begin
            failRun($sformatf("ERROR at %0t: %s expected %0d, got %0d",
                              $time, name, expected, actual));
        end
    endtask

    // an operand is checked field by field so the error names the wrong part
    task automatic compareOperand(input string name, input operand_t expected,
                                  input operand_t actual);
        compareBit({name, ".ready"}, expected.ready, actual.ready);
        compareWord({name, ".value"}, expected.value, actual.value);
    endtask

    task automatic compareCommit(input string name, input commit_t expected,
                                 input commit_t actual);
        if (actual !== expected) begin
            failRun($sformatf("ERROR at %0t: %s expected dest=%0d data=%h, got dest=%0d data=%h",
                              $time, name, expected.dest, expected.data,
                              actual.dest, actual.data));
        end
    endtask

    function automatic operand_t makeOperand(input logic ready, input word_t value);
        operand_t op;
        op.ready = ready;
        op.value = value;
        return op;
    endfunction

    function automatic commit_t makeCommit(input regIndex_t dest, input word_t data);
        commit_t rec;
        rec.dest = dest;
        rec.data = data;
        return rec;
    endfunction

    // 32-bit xorshift, shifts 13, 17 and 5
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = randState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        randState = x;
        return x;
    endfunction

    function automatic regIndex_t randomReg();
        return regIndex_t'(xorshift32() % NUM_ARCH_REGS);
    endfunction

    // ======================================================================
    // reference model
    // ======================================================================

    // one clock edge of the rename slice, applied to the inputs of the cycle
    task automatic updateModel();
        logic      accept;
        regIndex_t dest;
        accept = dispatchValid && (liveTag.size() < NUM_ENTRIES);
        // the head retires once done, and only the newest producer writes back
        if ((liveTag.size() > 0) && liveDone[0]) begin
            dest = liveDest[0];
            if ((dest != '0) && (modelTag[dest] == liveTag[0])) begin
                modelValue[dest] = liveData[0];
                if (!(accept && (dispatchDest == dest))) begin
                    modelTag[dest] = '0;
                end
            end
            void'(liveTag.pop_front());
            void'(liveDest.pop_front());
            void'(liveDone.pop_front());
            void'(liveData.pop_front());
        end
        // completion only lands on a live entry that is still waiting
        if (completeValid) begin
            for (int i = 0; i < liveTag.size(); i++) begin
                if ((liveTag[i] == completeTag) && !liveDone[i]) begin
                    liveDone[i] = 1'b1;
                    liveData[i] = completeData;
                end
            end
        end
        if (accept) begin
            if (dispatchDest != '0) begin
                modelTag[dispatchDest] = modelTail;
            end
            liveTag.push_back(modelTail);
            liveDest.push_back(dispatchDest);
            liveDone.push_back(1'b0);
            liveData.push_back('0);
            // tags run 1 to 15 and skip zero on wrap
            modelTail = (modelTail == robTag_t'(NUM_ENTRIES)) ? robTag_t'(1) : modelTail + 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            updateModel();
        end
    end

    // expected operand for a register, bypassing a done producer
    task automatic expectOperand(input regIndex_t index, output operand_t op,
                                 output robTag_t tag);
        op  = makeOperand(1'b1, modelValue[index]);
        tag = '0;
        if (modelTag[index] != '0) begin
            op  = makeOperand(1'b0, '0);
            tag = modelTag[index];
            for (int i = 0; i < liveTag.size(); i++) begin
                if ((liveTag[i] == modelTag[index]) && liveDone[i]) begin
                    op  = makeOperand(1'b1, liveData[i]);
                    tag = '0;
                end
            end
        end
    endtask

    // compares every output with the model, once per cycle
    task automatic checkState();
        operand_t expOp;
        robTag_t  expTag;
        logic     expCommit;
        compareBit("robFull", liveTag.size() == NUM_ENTRIES, robFull);
        compareTag("dispatchTag", modelTail, dispatchTag);
        expCommit = (liveTag.size() > 0) && liveDone[0];
        compareBit("commitValid", expCommit, commitValid);
        if (expCommit) begin
            compareCommit("commit", makeCommit(liveDest[0], liveData[0]), commit);
            seenCommits.push_back(commit);
        end
        expectOperand(readIndexA, expOp, expTag);
        compareOperand("operandA", expOp, operandA);
        compareTag("operandTagA", expTag, operandTagA);
        expectOperand(readIndexB, expOp, expTag);
        compareOperand("operandB", expOp, operandB);
        compareTag("operandTagB", expTag, operandTagB);
    endtask

    // ======================================================================
    // cycle drivers
    // ======================================================================

    // inputs change on the rising edge and are checked at the falling edge
    task automatic stepCycle(input logic dv, input regIndex_t dest, input logic cv,
                             input robTag_t ctag, input word_t cdata);
        @(posedge clk);
        dispatchValid <= dv;
        dispatchDest  <= dest;
        completeValid <= cv;
        completeTag   <= ctag;
        completeData  <= cdata;
        readIndexA    <= nextReadA;
        readIndexB    <= nextReadB;
        @(negedge clk);
        checkState();
        lastTag = dispatchTag;
    endtask

    task automatic idleCycle();
        stepCycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic dispatchTo(input regIndex_t dest, output robTag_t tag);
        stepCycle(1'b1, dest, 1'b0, '0, '0);
        tag = lastTag;
    endtask

    task automatic completeWith(input robTag_t tag, input word_t data);
        stepCycle(1'b0, '0, 1'b1, tag, data);
    endtask

    // the cycle counter bounds this wait
    task automatic waitCommits(input int count);
        while (seenCommits.size() < count) begin
            idleCycle();
        end
    endtask

    task automatic sweepRegisters();
        for (int i = 0; i < NUM_ARCH_REGS; i += 2) begin
            nextReadA = regIndex_t'(i);
            nextReadB = regIndex_t'(i + 1);
            idleCycle();
        end
    endtask

    // completes the given tags in random order, reading random registers
    task automatic drainRandom(inout robTag_t pending [$]);
        int pick;
        while (pending.size() > 0) begin
            pick      = xorshift32() % pending.size();
            nextReadA = randomReg();
            nextReadB = randomReg();
            completeWith(pending[pick], xorshift32());
            pending.delete(pick);
        end
    endtask

    // ======================================================================
    // tests
    // ======================================================================

    task automatic checkResetState();
        for (int i = 0; i < NUM_ARCH_REGS; i += 2) begin
            nextReadA = regIndex_t'(i);
            nextReadB = regIndex_t'(i + 1);
            idleCycle();
            compareOperand("operandA", makeOperand(1'b1, '0), operandA);
            compareOperand("operandB", makeOperand(1'b1, '0), operandB);
            compareTag("operandTagA", '0, operandTagA);
            compareTag("operandTagB", '0, operandTagB);
            compareBit("robFull", 1'b0, robFull);
            compareBit("commitValid", 1'b0, commitValid);
            compareTag("dispatchTag", robTag_t'(1), dispatchTag);
        end
    endtask

    task automatic runSingleLifecycle();
        robTag_t tag;
        word_t   data;
        nextReadA = 5;
        nextReadB = 0;
        dispatchTo(5, tag);
        idleCycle();
        compareOperand("operandA", makeOperand(1'b0, '0), operandA);
        compareTag("operandTagA", tag, operandTagA);
        data = xorshift32();
        completeWith(tag, data);
        idleCycle();
        // result arrives through the bypass while the entry waits to retire
        compareOperand("operandA", makeOperand(1'b1, data), operandA);
        compareBit("commitValid", 1'b1, commitValid);
        compareCommit("commit", makeCommit(5, data), commit);
        idleCycle();
        compareOperand("operandA", makeOperand(1'b1, data), operandA);
        compareTag("operandTagA", '0, operandTagA);
        compareBit("commitValid", 1'b0, commitValid);
    endtask

    task automatic runInOrderRetire();
        robTag_t tags [3];
        word_t   data [3];
        seenCommits.delete();
        nextReadA = 1;
        nextReadB = 2;
        for (int i = 0; i < 3; i++) begin
            dispatchTo(regIndex_t'(i + 1), tags[i]);
            data[i] = xorshift32();
        end
        for (int i = 2; i > 0; i--) begin
            completeWith(tags[i], data[i]);
            idleCycle();
        end
        if (seenCommits.size() != 0) begin
            failRun("in-order retirement: a younger entry retired before the oldest was done");
        end
        completeWith(tags[0], data[0]);
        waitCommits(3);
        for (int i = 0; i < 3; i++) begin
            compareCommit("commit", makeCommit(regIndex_t'(i + 1), data[i]), seenCommits[i]);
        end
    endtask

    task automatic runNewestWins();
        robTag_t oldTag;
        robTag_t youngTag;
        word_t   youngData;
        seenCommits.delete();
        nextReadA = 7;
        nextReadB = 5;
        dispatchTo(7, oldTag);
        dispatchTo(7, youngTag);
        youngData = xorshift32();
        completeWith(oldTag, xorshift32());
        waitCommits(1);
        idleCycle();
        // the older write-back was dropped, so register 7 still waits
        compareOperand("operandA", makeOperand(1'b0, '0), operandA);
        compareTag("operandTagA", youngTag, operandTagA);
        completeWith(youngTag, youngData);
        waitCommits(2);
        idleCycle();
        compareOperand("operandA", makeOperand(1'b1, youngData), operandA);
        compareTag("operandTagA", '0, operandTagA);
    endtask

    task automatic runRegisterZero();
        robTag_t tag;
        word_t   data;
        seenCommits.delete();
        nextReadA = 0;
        nextReadB = 7;
        dispatchTo(0, tag);
        idleCycle();
        compareOperand("operandA", makeOperand(1'b1, '0), operandA);
        compareTag("operandTagA", '0, operandTagA);
        data = xorshift32();
        completeWith(tag, data);
        waitCommits(1);
        idleCycle();
        compareCommit("commit", makeCommit(0, data), seenCommits[0]);
        compareOperand("operandA", makeOperand(1'b1, '0), operandA);
        compareTag("operandTagA", '0, operandTagA);
    endtask

    task automatic runFullAndWrap();
        robTag_t pending [$];
        robTag_t tag;
        robTag_t prevTag;
        robTag_t heldTag;
        logic    wrapped;
        int      issued;
        seenCommits.delete();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            nextReadA = randomReg();
            nextReadB = randomReg();
            dispatchTo(randomReg(), tag);
            pending.push_back(tag);
        end
        idleCycle();
        compareBit("robFull", 1'b1, robFull);
        heldTag = dispatchTag;
        // this dispatch must be dropped while the buffer is full
        dispatchTo(randomReg(), tag);
        idleCycle();
        compareTag("dispatchTag", heldTag, dispatchTag);
        compareBit("robFull", 1'b1, robFull);
        drainRandom(pending);
        waitCommits(NUM_ENTRIES);
        wrapped = 1'b0;
        issued  = 0;
        prevTag = '0;
        while (!wrapped && (issued < NUM_ENTRIES)) begin
            nextReadA = randomReg();
            dispatchTo(randomReg(), tag);
            if (tag == '0) begin
                failRun("full and wrap: a dispatch was given tag zero");
            end
            wrapped = (prevTag == robTag_t'(NUM_ENTRIES)) && (tag == robTag_t'(1));
            prevTag = tag;
            pending.push_back(tag);
            issued++;
        end
        if (!wrapped) begin
            failRun("full and wrap: the dispatch tag never wrapped from 15 to 1");
        end
        drainRandom(pending);
        waitCommits(NUM_ENTRIES + issued);
        sweepRegisters();
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        rst           = 1'b1;
        dispatchValid = 1'b0;
        dispatchDest  = '0;
        completeValid = 1'b0;
        completeTag   = '0;
        completeData  = '0;
        readIndexA    = '0;
        readIndexB    = '0;
        nextReadA     = '0;
        nextReadB     = '0;
        randState     = 32'd96;
        modelTail     = robTag_t'(1);
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            modelValue[i] = '0;
            modelTag[i]   = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        checkResetState();
        runSingleLifecycle();
        runInOrderRetire();
        runNewestWins();
        runRegisterZero();
        runFullAndWrap();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* hdl/renameCore.sv */
`timescale 1ns/100ps

module renameCore #(
    parameter int ROB_EN_WIDTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    // dispatch
    input  logic                    dispatchValid,
    input  renamePkg::regIndex_t    dispatchDest,
    output logic [ROB_EN_WIDTH-1:0] dispatchTag,
    output logic                    robFull,
    // completion
    input  logic                    completeValid,
    input  logic [ROB_EN_WIDTH-1:0] completeTag,
    input  renamePkg::word_t        completeData,
    // operand reads
    input  renamePkg::regIndex_t    readIndexA,
    input  renamePkg::regIndex_t    readIndexB,
    output renamePkg::operand_t     operandA,
    output renamePkg::operand_t     operandB,
    output logic [ROB_EN_WIDTH-1:0] operandTagA,
    output logic [ROB_EN_WIDTH-1:0] operandTagB,
    // retirement
    output logic                    commitValid,
    output renamePkg::commit_t      commit
);

    import renamePkg::*;

    // ======================================================================
    // internal wiring between the two halves
    // ======================================================================

    // accepted dispatch renames its destination in the register file
    logic                    allocValid;
    logic [ROB_EN_WIDTH-1:0] allocTag;
    // retiring entry's tag for the newest-producer check
    logic [ROB_EN_WIDTH-1:0] commitTag;
    // unresolved register file reads
    word_t                   rawValueA;
    word_t                   rawValueB;
    logic [ROB_EN_WIDTH-1:0] rawTagA;
    logic [ROB_EN_WIDTH-1:0] rawTagB;

    // architectural registers with their producer tags
    regFile #(
        .ROB_EN_WIDTH(ROB_EN_WIDTH)
    ) regFileInst (
        .clk        (clk),
        .rst        (rst),
        .allocValid (allocValid),
        .allocDest  (dispatchDest),
        .allocTag   (allocTag),
        .commitValid(commitValid),
        .commit     (commit),
        .commitTag  (commitTag),
        .readIndexA (readIndexA),
        .readIndexB (readIndexB),
        .rawValueA  (rawValueA),
        .rawValueB  (rawValueB),
        .rawTagA    (rawTagA),
        .rawTagB    (rawTagB)
    );

    // tag allocation, completion, retirement and operand bypass
    reorderBuffer #(
        .ROB_EN_WIDTH(ROB_EN_WIDTH)
    ) reorderBufferInst (
        .clk          (clk),
        .rst          (rst),
        .dispatchValid(dispatchValid),
        .dispatchDest (dispatchDest),
        .completeValid(completeValid),
        .completeTag  (completeTag),
        .completeData (completeData),
        .rawValueA    (rawValueA),
        .rawValueB    (rawValueB),
        .rawTagA      (rawTagA),
        .rawTagB      (rawTagB),
        .dispatchTag  (dispatchTag),
        .robFull      (robFull),
        .allocValid   (allocValid),
        .allocTag     (allocTag),
        .commitValid  (commitValid),
        .commit       (commit),
        .commitTag    (commitTag),
        .operandA     (operandA),
        .operandB     (operandB),
        .operandTagA  (operandTagA),
        .operandTagB  (operandTagB)
    );

endmodule

/* hdl/reorderBuffer.sv */
`timescale 1ns/100ps

module reorderBuffer #(
    parameter int ROB_EN_WIDTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    // dispatch side
    input  logic                    dispatchValid,
    input  renamePkg::regIndex_t    dispatchDest,
    // completion from the execution units
    input  logic                    completeValid,
    input  logic [ROB_EN_WIDTH-1:0] completeTag,
    input  renamePkg::word_t        completeData,
    // raw register file reads to be resolved
    input  renamePkg::word_t        rawValueA,
    input  renamePkg::word_t        rawValueB,
    input  logic [ROB_EN_WIDTH-1:0] rawTagA,
    input  logic [ROB_EN_WIDTH-1:0] rawTagB,
    // allocation state
    output logic [ROB_EN_WIDTH-1:0] dispatchTag,
    output logic                    robFull,
    output logic                    allocValid,
    output logic [ROB_EN_WIDTH-1:0] allocTag,
    // in-order retirement
    output logic                    commitValid,
    output renamePkg::commit_t      commit,
    output logic [ROB_EN_WIDTH-1:0] commitTag,
    // resolved operands
    output renamePkg::operand_t     operandA,
    output renamePkg::operand_t     operandB,
    output logic [ROB_EN_WIDTH-1:0] operandTagA,
    output logic [ROB_EN_WIDTH-1:0] operandTagB
);

    import renamePkg::*;

    typedef logic [ROB_EN_WIDTH-1:0] robTag_t;

    // tag zero is reserved, which leaves one entry fewer than the tag space
    localparam int NUM_ENTRIES = (1 << ROB_EN_WIDTH) - 1;

    // ======================================================================
    // entry store, indexed directly by tag
    // ======================================================================

    // slot 0 is never allocated and keeps live and done low after reset
    logic      entryLive   [NUM_ENTRIES + 1];
    logic      entryDone   [NUM_ENTRIES + 1];
    regIndex_t entryDest   [NUM_ENTRIES + 1];
    word_t     entryResult [NUM_ENTRIES + 1];

    // oldest entry, next free entry and occupancy
    robTag_t                 headTag;
    robTag_t                 tailTag;
    logic [ROB_EN_WIDTH-1:0] entryCount;

    // a completion that hits a live entry still waiting for its result
    logic completeHit;

    // step a pointer around the ring 1 .. NUM_ENTRIES, skipping zero on wrap
    function automatic robTag_t nextTag(input robTag_t tag);
        robTag_t result;
        if (tag == robTag_t'(NUM_ENTRIES)) begin
            result = robTag_t'(1);
        end else begin
            result = tag + robTag_t'(1);
        end
        return result;
    endfunction

    // turn a raw register read into an operand
    // a zero tag means the register file value is current, a done entry
    // forwards its result, anything else is still being computed
    function automatic operand_t resolveOperand(input word_t value, input robTag_t tag);
        operand_t result;
        if (tag == '0) begin
            result.ready = 1'b1;
            result.value = value;
        end else if (entryDone[tag]) begin
            result.ready = 1'b1;
            result.value = entryResult[tag];
        end else begin
            result.ready = 1'b0;
            result.value = '0;
        end
        return result;
    endfunction

    // ======================================================================
    // allocation and retirement handshakes
    // ======================================================================

    assign robFull     = (entryCount == robTag_t'(NUM_ENTRIES));
    // the tail is always the tag the next dispatch receives
    assign dispatchTag = tailTag;
    // dispatch while full is simply dropped
    assign allocValid  = dispatchValid && !robFull;
    assign allocTag    = tailTag;

    // the head retires as soon as its result is in
    assign commitValid = entryLive[headTag] && entryDone[headTag];
    assign commit      = '{dest: entryDest[headTag], data: entryResult[headTag]};
    assign commitTag   = headTag;

    // stale or repeated completions are ignored
    assign completeHit = completeValid && (completeTag != '0) && entryLive[completeTag]
                         && !entryDone[completeTag];

    // ======================================================================
    // operand resolution
    // ======================================================================

    always_comb begin
        operandA = resolveOperand(rawValueA, rawTagA);
        operandB = resolveOperand(rawValueB, rawTagB);
    end

    // the tag is only meaningful while the operand waits
    assign operandTagA = operandA.ready ? '0 : rawTagA;
    assign operandTagB = operandB.ready ? '0 : rawTagB;

    // ======================================================================
    // entry state
    // ======================================================================

    // while not full the tail differs from a live head, and while full no
    // allocation happens, so allocate and retire never hit the same slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i <= NUM_ENTRIES; i++) begin
                entryLive[i] <= 1'b0;
                entryDone[i] <= 1'b0;
            end
        end else begin
            if (commitValid) begin
                entryLive[headTag] <= 1'b0;
                entryDone[headTag] <= 1'b0;
            end
            if (completeHit) begin
                entryDone[completeTag] <= 1'b1;
            end
            if (allocValid) begin
                entryLive[tailTag] <= 1'b1;
                entryDone[tailTag] <= 1'b0;
            end
        end
    end

    // payload is only looked at while its entry is live and done
    always_ff @(posedge clk) begin
        if (allocValid) begin
            entryDest[tailTag] <= dispatchDest;
        end
        if (completeHit) begin
            entryResult[completeTag] <= completeData;
        end
    end

    // ring pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            headTag    <= robTag_t'(1);
            tailTag    <= robTag_t'(1);
            entryCount <= '0;
        end else begin
            if (allocValid) begin
                tailTag <= nextTag(tailTag);
            end
            if (commitValid) begin
                headTag <= nextTag(headTag);
            end
            case ({allocValid, commitValid})
                2'b10:   entryCount <= entryCount + 1'b1;
                2'b01:   entryCount <= entryCount - 1'b1;
                default: entryCount <= entryCount;
            endcase
        end
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/100ps

module regFile #(
    parameter int ROB_EN_WIDTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    // rename request coming from an accepted dispatch
    input  logic                    allocValid,
    input  renamePkg::regIndex_t    allocDest,
    input  logic [ROB_EN_WIDTH-1:0] allocTag,
    // retirement write-back from the reorder buffer head
    input  logic                    commitValid,
    input  renamePkg::commit_t      commit,
    input  logic [ROB_EN_WIDTH-1:0] commitTag,
    // two combinational read ports
    input  renamePkg::regIndex_t    readIndexA,
    input  renamePkg::regIndex_t    readIndexB,
    output renamePkg::word_t        rawValueA,
    output renamePkg::word_t        rawValueB,
    output logic [ROB_EN_WIDTH-1:0] rawTagA,
    output logic [ROB_EN_WIDTH-1:0] rawTagB
);

    import renamePkg::*;

    // a reorder buffer tag, where zero stands for "no producer in flight"
    typedef logic [ROB_EN_WIDTH-1:0] robTag_t;

    // ======================================================================
    // storage
    // ======================================================================

    // committed value of each architectural register
    word_t   regValue [NUM_ARCH_REGS];
    // tag of the newest in-flight producer of each register
    robTag_t regTag   [NUM_ARCH_REGS];

    // qualified update strobes
    logic renameHit;
    logic writeBackHit;
    logic tagClear;

    // ======================================================================
    // update conditions
    // ======================================================================

    // x0 is never renamed and tag zero is never recorded
    assign renameHit = allocValid && (allocDest != '0) && (allocTag != '0);

    // only the newest producer of a register may write it back
    // an older producer finds a younger tag stored and its data is dropped
    assign writeBackHit = commitValid && (commit.dest != '0) && (commitTag != '0)
                          && (regTag[commit.dest] == commitTag);

    // once the newest producer retires the register has no producer left,
    // so the tag goes back to zero
    // a dispatch renaming the same register in this cycle keeps its fresh tag
    assign tagClear = writeBackHit && !(renameHit && (allocDest == commit.dest));

    // ======================================================================
    // read ports
    // ======================================================================

    // x0 is never written, so it keeps its reset value of zero with tag zero
    assign rawValueA = regValue[readIndexA];
    assign rawValueB = regValue[readIndexB];
    assign rawTagA   = regTag[readIndexA];
    assign rawTagB   = regTag[readIndexB];

    // ======================================================================
    // register state
    // ======================================================================

    // data array, written only by a tag-matched retirement
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                regValue[i] <= '0;
            end
        end else if (writeBackHit) begin
            regValue[commit.dest] <= commit.data;
        end
    end

    // producer tags, set at dispatch and cleared by the matching retirement
    // tagClear never targets the renamed register, so both may fire together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                regTag[i] <= '0;
            end
        end else begin
            if (tagClear) begin
                regTag[commit.dest] <= '0;
            end
            if (renameHit) begin
                regTag[allocDest] <= allocTag;
            end
        end
    end

endmodule

/* hdl/renamePkg.sv */
package renamePkg;

    // ======================================================================
    // architectural state
    // ======================================================================

    // registers visible to software, x0 included
    localparam int NUM_ARCH_REGS = 32;

    // one data word as it moves through the core
    typedef logic [31:0] word_t;

    // index of an architectural register
    typedef logic [4:0] regIndex_t;

    // ======================================================================
    // records exchanged between the register file and the reorder buffer
    // ======================================================================

    // a source operand after renaming
    // with ready low the consumer waits on the tag that travels beside it,
    // and value is held at zero in that case
    typedef struct packed {
        logic  ready;
        word_t value;
    } operand_t;

    // the write-back of one retiring instruction
    // it is qualified by a separate commit strobe and carries no valid bit
    typedef struct packed {
        regIndex_t dest;
        word_t     data;
    } commit_t;

endpackage
